/* tests/cpu_trace.txt */
// word 0 is the program length in words, word 1 the number of writeback records.
// then the program image from 0x1c000000, then one record per line: pc, wnum, wdata.
0000001b 00000014
// r1 = -5 and r2 = 7, then add, sub, slt, sltu, nor, and, or, xor.
02bfec01 02801c02 00100823 00110444 00120825 00128826
00140c47 00148828 00150829 0015882a
// lu12i.w, slli.w, srli.w, srai.w, and r15 = 0x100 as data base.
1500246b 0040916c 0044a16d 0048a16e 0284000f
// st.w, ld.w of it, ld.w of an unwritten word, taken beq, skipped addi.w, untaken bne.
298021eb 288021f0 288031f1 58000a0b 02800412 5c000c42
// bl, add.w after return, self loop, b over one addi.w, jirl back through r1.
54000c00 00100813 50000000 50000800 02800414 4c000020
1c000000 01 fffffffb
1c000004 02 00000007
1c000008 03 00000002
1c00000c 04 0000000c
1c000010 05 00000001
1c000014 06 00000000
1c000018 07 fffffff8
1c00001c 08 00000003
1c000020 09 ffffffff
1c000024 0a fffffffc
1c000028 0b 80123000
1c00002c 0c 01230000
1c000030 0d 00801230
1c000034 0e ff801230
1c000038 0f 00000100
1c000040 10 80123000
1c000044 11 00000000
1c000054 01 1c000058
1c000068 00 1c00006c
1c000058 13 00000007

/* la32_mcycle.f */
src/la32_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_ifs.sv
src/alu.sv
src/regfile.sv
src/inst_decoder.sv
src/mcycle_core.sv
src/la32_mcycle_top.sv
tests/tb_top_chk.sv
tests/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench and RTL with Verilator, run it, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/100ps --top-module tb_top \
    -f la32_mcycle.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "log reports success" \
    || { echo "log reports no success"; exit 1; }

/* tests/tb_top.sv */
`timescale 1ns/100ps

module tb_top;

    localparam int TRACE_WORDS = 128;
    localparam int MEM_AW      = 8;
    localparam int MEM_WORDS   = 2 ** MEM_AW;

    logic                            clk;
    logic                            reset;
    logic                            inst_sram_we;
    logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_addr;
    logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_wdata;
    logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_rdata;
    logic                            data_sram_we;
    logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_addr;
    logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_wdata;
    logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_rdata;
    logic [cpu_ctrl_pkg::XLEN-1:0]   debug_wb_pc;
    logic [3:0]                      debug_wb_rf_we;
    logic [cpu_ctrl_pkg::REG_AW-1:0] debug_wb_rf_wnum;
    logic [cpu_ctrl_pkg::XLEN-1:0]   debug_wb_rf_wdata;

    // the trace holds two counts, the program image, then pc, wnum and wdata per record.
    logic [cpu_ctrl_pkg::XLEN-1:0] trace_mem [TRACE_WORDS];
    logic [cpu_ctrl_pkg::XLEN-1:0] imem [MEM_WORDS];
    logic [cpu_ctrl_pkg::XLEN-1:0] dmem [MEM_WORDS];
    int n_prog;
    int n_rec;
    int rec_base;
    int limit;
    int rec_idx;
    int cycles;
    int errors;
    int assert_fails;

    la32_mcycle_top dut_i (.*);

    function automatic int word_index(input logic [cpu_ctrl_pkg::XLEN-1:0] addr);
        return int'(addr[MEM_AW+1:2]);
    endfunction

    task automatic load_trace();
        $readmemh("tests/cpu_trace.txt", trace_mem);
        n_prog   = int'(trace_mem[0]);
        n_rec    = int'(trace_mem[1]);
        rec_base = 2 + n_prog;
        limit    = 5 * n_rec + 20;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int i = 0; i < n_prog && i < MEM_WORDS; i++) begin
            imem[i] = trace_mem[2 + i];
        end
    endtask

    task automatic check_pc(input logic [cpu_ctrl_pkg::XLEN-1:0] expected,
                            input logic [cpu_ctrl_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED debug_wb_pc record %0d expected %h actual %h",
                     rec_idx, expected, actual);
        end
    endtask

    task automatic check_wnum(input logic [cpu_ctrl_pkg::REG_AW-1:0] expected,
                              input logic [cpu_ctrl_pkg::REG_AW-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED debug_wb_rf_wnum record %0d expected %h actual %h",
                     rec_idx, expected, actual);
        end
    endtask

    task automatic check_wdata(input logic [cpu_ctrl_pkg::XLEN-1:0] expected,
                               input logic [cpu_ctrl_pkg::XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED debug_wb_rf_wdata record %0d expected %h actual %h",
                     rec_idx, expected, actual);
        end
    endtask

    task automatic check_wen(input logic [3:0] expected,
                             input logic [3:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED debug_wb_rf_we record %0d expected %h actual %h",
                     rec_idx, expected, actual);
        end
    endtask

    // the instruction SRAM is never written, so its write port stays at zero.
    task automatic check_imem_idle(input logic                          we,
                                   input logic [cpu_ctrl_pkg::XLEN-1:0] wdata);
        if (we !== 1'b0) begin
            errors++;
            $display("CHECK FAILED inst_sram_we cycle %0d expected %h actual %h",
                     cycles, 1'b0, we);
        end
        if (wdata !== '0) begin
            errors++;
            $display("CHECK FAILED inst_sram_wdata cycle %0d expected %h actual %h",
                     cycles, {cpu_ctrl_pkg::XLEN{1'b0}}, wdata);
        end
    endtask

    task automatic compare_record();
        int b;
        b = rec_base + 3 * rec_idx;
        check_wen(4'hf, debug_wb_rf_we);
        check_pc(trace_mem[b], debug_wb_pc);
        check_wnum(cpu_ctrl_pkg::REG_AW'(trace_mem[b + 1]), debug_wb_rf_wnum);
        check_wdata(trace_mem[b + 2], debug_wb_rf_wdata);
        rec_idx++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // both SRAMs sample in mid cycle and answer on the next cycle.
    initial begin
        logic [cpu_ctrl_pkg::XLEN-1:0] inst_addr_q;
        logic [cpu_ctrl_pkg::XLEN-1:0] data_addr_q;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        load_trace();
        forever begin
            @(negedge clk);
            inst_addr_q = inst_sram_addr;
            data_addr_q = data_sram_addr;
            if (data_sram_we) begin
                dmem[word_index(data_sram_addr)] = data_sram_wdata;
            end
            @(posedge clk);
            #2;
            inst_sram_rdata = imem[word_index(inst_addr_q)];
            data_sram_rdata = dmem[word_index(data_addr_q)];
        end
    end

    initial begin
        reset   = 1'b1;
        rec_idx = 0;
        cycles  = 0;
        errors  = 0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        if (n_prog == 0 || n_rec == 0) begin
            errors++;
            $display("trace file tests/cpu_trace.txt is missing or holds no records");
        end
        while (rec_idx < n_rec && cycles <= limit) begin
            @(negedge clk);
            cycles++;
            check_imem_idle(inst_sram_we, inst_sram_wdata);
            if (debug_wb_rf_we != 4'h0) begin
                compare_record();
            end
        end
        if (rec_idx < n_rec) begin
            errors++;
            $display("timeout after %0d cycles with only %0d of %0d records retired",
                     cycles, rec_idx, n_rec);
        end
        assert_fails = dut_i.core_i.chk_i.fail_count;
        $display("errors %0d, assertion failures %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tests/tb_top_chk.sv */
`timescale 1ns/100ps

module tb_top_chk (
    input logic                          clk,
    input logic                          reset,
    input logic [cpu_ctrl_pkg::ST_W-1:0] state,
    input logic                          data_sram_we,
    input logic [3:0]                    debug_wb_rf_we
);

    int fail_count = 0;

    logic [cpu_ctrl_pkg::ST_W-1:0] state_after;

    // WB wraps around to IF, every other state steps to the next code.
    assign state_after = (state == cpu_ctrl_pkg::ST_WB) ? cpu_ctrl_pkg::ST_IF
                                                         : state + cpu_ctrl_pkg::ST_W'(1);

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state <= cpu_ctrl_pkg::ST_WB)
        else begin
            fail_count++;
            $error("state register holds a code outside IF to WB");
        end

    state_order: assert property (@(posedge clk) disable iff (reset)
        !reset |=> state == $past(state_after))
        else begin
            fail_count++;
            $error("state register did not advance to the next state");
        end

    store_in_mem: assert property (@(posedge clk) disable iff (reset)
        data_sram_we |-> state == cpu_ctrl_pkg::ST_MEM)
        else begin
            fail_count++;
            $error("data SRAM write strobe raised outside MEM");
        end

    debug_in_wb: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_we != 4'h0 |-> state == cpu_ctrl_pkg::ST_WB)
        else begin
            fail_count++;
            $error("debug register write enable raised outside WB");
        end

endmodule

bind mcycle_core tb_top_chk chk_i (
    .clk            (clk),
    .reset          (reset),
    .state          (state),
    .data_sram_we   (data_sram_we),
    .debug_wb_rf_we (debug_wb_rf_we)
);

/* src/la32_mcycle_top.sv */
`timescale 1ns/100ps

module la32_mcycle_top (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            inst_sram_we,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_addr,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_wdata,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]   inst_sram_rdata,
    output logic                            data_sram_we,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_addr,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_wdata,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]   data_sram_rdata,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   debug_wb_pc,
    output logic [3:0]                      debug_wb_rf_we,
    output logic [cpu_ctrl_pkg::REG_AW-1:0] debug_wb_rf_wnum,
    output logic [cpu_ctrl_pkg::XLEN-1:0]   debug_wb_rf_wdata
);

    la32_isa_pkg::inst_word_u         inst;
    logic [cpu_ctrl_pkg::ALU_OPS-1:0] alu_op;
    logic [cpu_ctrl_pkg::XLEN-1:0]    alu_src1;
    logic [cpu_ctrl_pkg::XLEN-1:0]    alu_src2;
    logic [cpu_ctrl_pkg::XLEN-1:0]    alu_result;

    ctrl_if ctrl ();
    rf_if   rf ();

    // the instruction memory is read only.
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    mcycle_core core_i (
        .clk               (clk),
        .reset             (reset),
        .ctrl              (ctrl.core),
        .rf                (rf.core),
        .inst              (inst),
        .alu_op            (alu_op),
        .alu_src1          (alu_src1),
        .alu_src2          (alu_src2),
        .alu_result        (alu_result),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    inst_decoder dec_i (
        .inst (inst),
        .ctrl (ctrl.dec)
    );

    regfile rf_i (
        .clk (clk),
        .rf  (rf.rf)
    );

    alu alu_i (
        .alu_op (alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

endmodule

/* src/mcycle_core.sv */
`timescale 1ns/100ps

module mcycle_core (
    input  logic                             clk,
    input  logic                             reset,
    ctrl_if.core                             ctrl,
    rf_if.core                               rf,
    output la32_isa_pkg::inst_word_u         inst,
    output logic [cpu_ctrl_pkg::ALU_OPS-1:0] alu_op,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    alu_src1,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    alu_src2,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]    alu_result,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    inst_sram_addr,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]    inst_sram_rdata,
    output logic                             data_sram_we,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    data_sram_addr,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    data_sram_wdata,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]    data_sram_rdata,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    debug_wb_pc,
    output logic [3:0]                       debug_wb_rf_we,
    output logic [cpu_ctrl_pkg::REG_AW-1:0]  debug_wb_rf_wnum,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    debug_wb_rf_wdata
);

    logic [cpu_ctrl_pkg::ST_W-1:0] state;
    logic [cpu_ctrl_pkg::ST_W-1:0] state_nxt;
    logic [cpu_ctrl_pkg::XLEN-1:0] pc;
    logic [cpu_ctrl_pkg::XLEN-1:0] result_q;
    logic [cpu_ctrl_pkg::XLEN-1:0] store_q;
    logic [cpu_ctrl_pkg::XLEN-1:0] next_pc_q;
    logic [cpu_ctrl_pkg::XLEN-1:0] br_target;
    logic [cpu_ctrl_pkg::XLEN-1:0] final_result;
    logic                          br_taken;
    logic                          wb_we;

    always_comb begin
        unique case (state)
            cpu_ctrl_pkg::ST_IF:  state_nxt = cpu_ctrl_pkg::ST_ID;
            cpu_ctrl_pkg::ST_ID:  state_nxt = cpu_ctrl_pkg::ST_EXE;
            cpu_ctrl_pkg::ST_EXE: state_nxt = cpu_ctrl_pkg::ST_MEM;
            cpu_ctrl_pkg::ST_MEM: state_nxt = cpu_ctrl_pkg::ST_WB;
            default:              state_nxt = cpu_ctrl_pkg::ST_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_ctrl_pkg::ST_IF;
            pc    <= cpu_ctrl_pkg::RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == cpu_ctrl_pkg::ST_WB) begin
                pc <= next_pc_q;
            end
        end
    end

    // the instruction register holds the word from ID until the next fetch.
    always_ff @(posedge clk) begin
        if (state == cpu_ctrl_pkg::ST_ID) begin
            inst <= inst_sram_rdata;
        end
        if (state == cpu_ctrl_pkg::ST_EXE) begin
            result_q  <= alu_result;
            store_q   <= rf.rdata2;
            next_pc_q <= br_taken ? br_target : pc + cpu_ctrl_pkg::XLEN'(4);
        end
    end

    assign rf.raddr1 = inst.r3.rj;
    assign rf.raddr2 = ctrl.src_reg_is_rd ? inst.r3.rd : inst.r3.rk;

    assign alu_op   = ctrl.alu_op;
    assign alu_src1 = ctrl.src1_is_pc ? pc : rf.rdata1;
    assign alu_src2 = ctrl.src2_is_imm ? ctrl.imm : rf.rdata2;

    // jirl jumps relative to rj, every other branch relative to its own PC.
    assign br_taken  = ctrl.is_jump | ctrl.is_jirl
                     | (ctrl.is_beq & (rf.rdata1 == rf.rdata2))
                     | (ctrl.is_bne & (rf.rdata1 != rf.rdata2));
    assign br_target = (ctrl.is_jirl ? rf.rdata1 : pc) + ctrl.br_offs;

    assign inst_sram_addr  = pc;
    assign data_sram_we    = (state == cpu_ctrl_pkg::ST_MEM) & ctrl.mem_we;
    assign data_sram_addr  = result_q;
    assign data_sram_wdata = store_q;

    assign final_result = ctrl.res_from_mem ? data_sram_rdata : result_q;
    assign wb_we        = (state == cpu_ctrl_pkg::ST_WB) & ctrl.gr_we;

    assign rf.we    = wb_we;
    assign rf.waddr = ctrl.dest;
    assign rf.wdata = final_result;

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{wb_we}};
    assign debug_wb_rf_wnum  = ctrl.dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

/* src/inst_decoder.sv */
`timescale 1ns/100ps

module inst_decoder (
    input  la32_isa_pkg::inst_word_u inst,
    ctrl_if.dec                      ctrl
);

    logic inst_add_w;
    logic inst_sub_w;
    logic inst_slt;
    logic inst_sltu;
    logic inst_nor;
    logic inst_and;
    logic inst_or;
    logic inst_xor;
    logic inst_slli_w;
    logic inst_srli_w;
    logic inst_srai_w;
    logic inst_addi_w;
    logic inst_ld_w;
    logic inst_st_w;
    logic inst_lu12i_w;
    logic inst_jirl;
    logic inst_b;
    logic inst_bl;
    logic inst_beq;
    logic inst_bne;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [25:0] i26;

    assign inst_add_w   = inst.r3.opcode == la32_isa_pkg::OPC_ADD_W;
    assign inst_sub_w   = inst.r3.opcode == la32_isa_pkg::OPC_SUB_W;
    assign inst_slt     = inst.r3.opcode == la32_isa_pkg::OPC_SLT;
    assign inst_sltu    = inst.r3.opcode == la32_isa_pkg::OPC_SLTU;
    assign inst_nor     = inst.r3.opcode == la32_isa_pkg::OPC_NOR;
    assign inst_and     = inst.r3.opcode == la32_isa_pkg::OPC_AND;
    assign inst_or      = inst.r3.opcode == la32_isa_pkg::OPC_OR;
    assign inst_xor     = inst.r3.opcode == la32_isa_pkg::OPC_XOR;
    assign inst_slli_w  = inst.r3.opcode == la32_isa_pkg::OPC_SLLI_W;
    assign inst_srli_w  = inst.r3.opcode == la32_isa_pkg::OPC_SRLI_W;
    assign inst_srai_w  = inst.r3.opcode == la32_isa_pkg::OPC_SRAI_W;
    assign inst_addi_w  = inst.ri12.opcode == la32_isa_pkg::OPC_ADDI_W;
    assign inst_ld_w    = inst.ri12.opcode == la32_isa_pkg::OPC_LD_W;
    assign inst_st_w    = inst.ri12.opcode == la32_isa_pkg::OPC_ST_W;
    assign inst_lu12i_w = inst.ri20.opcode == la32_isa_pkg::OPC_LU12I_W;
    assign inst_jirl    = inst.ri16.opcode == la32_isa_pkg::OPC_JIRL;
    assign inst_beq     = inst.ri16.opcode == la32_isa_pkg::OPC_BEQ;
    assign inst_bne     = inst.ri16.opcode == la32_isa_pkg::OPC_BNE;
    assign inst_b       = inst.i26.opcode == la32_isa_pkg::OPC_B;
    assign inst_bl      = inst.i26.opcode == la32_isa_pkg::OPC_BL;

    // address arithmetic for loads, stores and link values all goes through the adder.
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w
                                               | inst_st_w | inst_jirl | inst_bl;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SUB]  = inst_sub_w;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SLT]  = inst_slt;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SLTU] = inst_sltu;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_AND]  = inst_and;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_NOR]  = inst_nor;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_OR]   = inst_or;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_XOR]  = inst_xor;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SLL]  = inst_slli_w;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SRL]  = inst_srli_w;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_SRA]  = inst_srai_w;
    assign ctrl.alu_op[cpu_ctrl_pkg::ALU_LUI]  = inst_lu12i_w;

    assign i12 = inst.ri12.imm12;
    assign i16 = inst.ri16.imm16;
    assign i26 = {inst.i26.offs_hi, inst.i26.offs_lo};

    // link instructions add 4 to the PC, the shift amount is the low five bits of i12.
    assign ctrl.imm = (inst_jirl | inst_bl) ? cpu_ctrl_pkg::XLEN'(4) :
                      inst_lu12i_w          ? {inst.ri20.imm20, 12'b0} :
                      {{(cpu_ctrl_pkg::XLEN-12){i12[11]}}, i12};

    assign ctrl.br_offs = (inst_b | inst_bl) ?
                          {{(cpu_ctrl_pkg::XLEN-28){i26[25]}}, i26, 2'b00} :
                          {{(cpu_ctrl_pkg::XLEN-18){i16[15]}}, i16, 2'b00};

    assign ctrl.src1_is_pc    = inst_jirl | inst_bl | inst_b;
    assign ctrl.src2_is_imm   = inst_slli_w | inst_srli_w | inst_srai_w | inst_addi_w
                              | inst_ld_w | inst_st_w | inst_lu12i_w | inst_jirl
                              | inst_bl | inst_b;
    assign ctrl.src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
    assign ctrl.res_from_mem  = inst_ld_w;
    assign ctrl.gr_we         = ~inst_st_w & ~inst_beq & ~inst_bne & ~inst_b;
    assign ctrl.mem_we        = inst_st_w;
    assign ctrl.dest          = inst_bl ? cpu_ctrl_pkg::REG_AW'(1) : inst.r3.rd;
    assign ctrl.is_jirl       = inst_jirl;
    assign ctrl.is_beq        = inst_beq;
    assign ctrl.is_bne        = inst_bne;
    assign ctrl.is_jump       = inst_b | inst_bl;

endmodule

/* src/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic clk,
    rf_if.rf     rf
);

    localparam int NREGS = 2 ** cpu_ctrl_pkg::REG_AW;

    logic [cpu_ctrl_pkg::XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (rf.we && rf.waddr != '0) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // r0 is never written, so its read is forced to zero.
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

/* src/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic [cpu_ctrl_pkg::ALU_OPS-1:0] alu_op,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]    src1,
    input  logic [cpu_ctrl_pkg::XLEN-1:0]    src2,
    output logic [cpu_ctrl_pkg::XLEN-1:0]    result
);

    localparam int MSB = cpu_ctrl_pkg::XLEN - 1;

    logic                          do_sub;
    logic [cpu_ctrl_pkg::XLEN-1:0] adder_b;
    logic [cpu_ctrl_pkg::XLEN-1:0] adder_res;
    logic                          adder_cout;
    logic                          slt_bit;
    logic                          sltu_bit;
    logic [4:0]                    shamt;

    // one adder serves add, sub and both compares.
    assign do_sub  = alu_op[cpu_ctrl_pkg::ALU_SUB] | alu_op[cpu_ctrl_pkg::ALU_SLT]
                   | alu_op[cpu_ctrl_pkg::ALU_SLTU];
    assign adder_b = do_sub ? ~src2 : src2;
    assign {adder_cout, adder_res} = {1'b0, src1} + {1'b0, adder_b}
                                   + (cpu_ctrl_pkg::XLEN + 1)'(do_sub);

    assign slt_bit  = (src1[MSB] & ~src2[MSB])
                    | (~(src1[MSB] ^ src2[MSB]) & adder_res[MSB]);
    assign sltu_bit = ~adder_cout;
    assign shamt    = src2[4:0];

    always_comb begin
        result = '0;
        unique case (1'b1)
            alu_op[cpu_ctrl_pkg::ALU_ADD],
            alu_op[cpu_ctrl_pkg::ALU_SUB]:  result = adder_res;
            alu_op[cpu_ctrl_pkg::ALU_SLT]:  result = cpu_ctrl_pkg::XLEN'(slt_bit);
            alu_op[cpu_ctrl_pkg::ALU_SLTU]: result = cpu_ctrl_pkg::XLEN'(sltu_bit);
            alu_op[cpu_ctrl_pkg::ALU_AND]:  result = src1 & src2;
            alu_op[cpu_ctrl_pkg::ALU_NOR]:  result = ~(src1 | src2);
            alu_op[cpu_ctrl_pkg::ALU_OR]:   result = src1 | src2;
            alu_op[cpu_ctrl_pkg::ALU_XOR]:  result = src1 ^ src2;
            alu_op[cpu_ctrl_pkg::ALU_SLL]:  result = src1 << shamt;
            alu_op[cpu_ctrl_pkg::ALU_SRL]:  result = src1 >> shamt;
            alu_op[cpu_ctrl_pkg::ALU_SRA]:  result = $signed(src1) >>> shamt;
            alu_op[cpu_ctrl_pkg::ALU_LUI]:  result = src2;
            default:                        result = '0;
        endcase
    end

endmodule

/* src/cpu_ifs.sv */
`timescale 1ns/100ps

interface ctrl_if;
    logic [cpu_ctrl_pkg::ALU_OPS-1:0] alu_op;
    logic                             src1_is_pc;
    logic                             src2_is_imm;
    logic                             src_reg_is_rd;
    logic                             res_from_mem;
    logic                             gr_we;
    logic                             mem_we;
    logic [cpu_ctrl_pkg::REG_AW-1:0]  dest;
    logic [cpu_ctrl_pkg::XLEN-1:0]    imm;
    logic [cpu_ctrl_pkg::XLEN-1:0]    br_offs;
    logic                             is_jirl;
    logic                             is_beq;
    logic                             is_bne;
    logic                             is_jump;

    modport dec (output alu_op, src1_is_pc, src2_is_imm, src_reg_is_rd, res_from_mem,
                 gr_we, mem_we, dest, imm, br_offs, is_jirl, is_beq, is_bne, is_jump);
    modport core (input alu_op, src1_is_pc, src2_is_imm, src_reg_is_rd, res_from_mem,
                  gr_we, mem_we, dest, imm, br_offs, is_jirl, is_beq, is_bne, is_jump);
endinterface

interface rf_if;
    logic [cpu_ctrl_pkg::REG_AW-1:0] raddr1;
    logic [cpu_ctrl_pkg::REG_AW-1:0] raddr2;
    logic [cpu_ctrl_pkg::XLEN-1:0]   rdata1;
    logic [cpu_ctrl_pkg::XLEN-1:0]   rdata2;
    logic                            we;
    logic [cpu_ctrl_pkg::REG_AW-1:0] waddr;
    logic [cpu_ctrl_pkg::XLEN-1:0]   wdata;

    modport core (output raddr1, raddr2, we, waddr, wdata, input rdata1, rdata2);
    modport rf (input raddr1, raddr2, we, waddr, wdata, output rdata1, rdata2);
endinterface

/* src/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1c000000;

    localparam int ST_W = 3;
    localparam logic [ST_W-1:0] ST_IF  = 3'd0;
    localparam logic [ST_W-1:0] ST_ID  = 3'd1;
    localparam logic [ST_W-1:0] ST_EXE = 3'd2;
    localparam logic [ST_W-1:0] ST_MEM = 3'd3;
    localparam logic [ST_W-1:0] ST_WB  = 3'd4;

    // bit positions in the one-hot ALU select.
    localparam int ALU_OPS  = 12;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

endpackage

/* src/la32_isa_pkg.sv */
package la32_isa_pkg;

    // one instruction word, viewed through each LA32R encoding format.
    typedef union packed {
        struct packed {
            logic [16:0] opcode;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  opcode;
            logic [11:0] imm12;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
        struct packed {
            logic [6:0]  opcode;
            logic [19:0] imm20;
            logic [4:0]  rd;
        } ri20;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] imm16;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri16;
        struct packed {
            logic [5:0]  opcode;
            logic [15:0] offs_lo;
            logic [9:0]  offs_hi;
        } i26;
    } inst_word_u;

    // three-register format, bits 31:15.
    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [16:0] OPC_SUB_W  = 17'h00022;
    localparam logic [16:0] OPC_SLT    = 17'h00024;
    localparam logic [16:0] OPC_SLTU   = 17'h00025;
    localparam logic [16:0] OPC_NOR    = 17'h00028;
    localparam logic [16:0] OPC_AND    = 17'h00029;
    localparam logic [16:0] OPC_OR     = 17'h0002a;
    localparam logic [16:0] OPC_XOR    = 17'h0002b;
    // shifts by immediate share the r3 layout, the shift amount sits in rk.
    localparam logic [16:0] OPC_SLLI_W = 17'h00081;
    localparam logic [16:0] OPC_SRLI_W = 17'h00089;
    localparam logic [16:0] OPC_SRAI_W = 17'h00091;

    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
    localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
    localparam logic [9:0]  OPC_ST_W   = 10'h0a6;

    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;

    localparam logic [5:0]  OPC_JIRL = 6'h13;
    localparam logic [5:0]  OPC_B    = 6'h14;
    localparam logic [5:0]  OPC_BL   = 6'h15;
    localparam logic [5:0]  OPC_BEQ  = 6'h16;
    localparam logic [5:0]  OPC_BNE  = 6'h17;

endpackage
